// ==== capture/frameCapture.sv ====
`default_nettype none

`include "capture_config.svh"

module frameCapture import capturePkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 lineDoubler,
    input  rasterPos             pos,
    input  pixel                 pixelIn,
    output capturePkg::ramWrite  ramWrite,
    output logic                 startTrigger
);

    logic [11:0] hStart;
    logic [11:0] hEnd;
    logic [11:0] vEnd;
    logic        inGap;
    logic        inWindow;
    logic        firstBuffer;

    logic [`RAM_ADDRESS_BITS-1:0] slotBase;
    logic [`RAM_ADDRESS_BITS-1:0] column;
    logic [`RAM_ADDRESS_BITS-1:0] writeAddr;

    // --------------------
    // window selection
    // --------------------
    always_comb begin
        if (lineDoubler) begin
            hStart = 12'(`D_H_START);
            hEnd   = 12'(`D_H_END);
            vEnd   = 12'(`D_V_END);
        end else begin
            hStart = 12'(`P_H_START);
            hEnd   = 12'(`P_H_END);
            vEnd   = 12'(`P_V_END);
        end
    end

    // no writes between the two fields
    assign inGap = lineDoubler
                && pos.y >= 12'(`D_GAP_START)
                && pos.y <  12'(`D_GAP_END);

    assign inWindow = pos.x >= hStart
                   && pos.x <  hEnd
                   && pos.y <  vEnd
                   && !inGap;

    assign firstBuffer = pos.y < 12'(`BUFFER_SIZE);

    // --------------------
    // ring addressing
    // --------------------
    // vertical start is line 0 in both modes
    assign slotBase  = `RAM_ADDRESS_BITS'(`BUFFER_LINE_LENGTH * (pos.y % `BUFFER_SIZE));
    assign column    = `RAM_ADDRESS_BITS'(pos.x - hStart);
    assign writeAddr = slotBase + column;

    // control
    always_ff @(posedge clock) begin
        if (reset) begin
            ramWrite.en  <= 1'b0;
            startTrigger <= 1'b0;
        end else begin
            ramWrite.en  <= inWindow;
            startTrigger <= inWindow
                         && firstBuffer
                         && writeAddr == `RAM_ADDRESS_BITS'(`TRIGGER_ADDR);
        end
    end

    // payload
    always_ff @(posedge clock) begin
        ramWrite.addr <= writeAddr;
        ramWrite.data <= pixelIn;
    end

endmodule

`default_nettype wire

// ==== common/capturePkg.sv ====
`default_nettype none

`include "capture_config.svh"

package capturePkg;

    // 24-bit RGB word, r in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel;

    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
    } rasterPos;

    // one write into the line buffer RAM
    typedef struct packed {
        logic                         en;
        logic [`RAM_ADDRESS_BITS-1:0] addr;
        pixel                         data;
    } ramWrite;

endpackage

`default_nettype wire

// ==== common/capture_config.svh ====
`ifndef CAPTURE_CONFIG_SVH
`define CAPTURE_CONFIG_SVH

// --------------------
// source raster
// --------------------
`define H_TOTAL             858     // pixels per line
`define V_TOTAL             525     // lines per frame

// --------------------
// ring of line buffers
// --------------------
`define BUFFER_LINE_LENGTH  640
`define BUFFER_SIZE         4       // lines in the ring
`define RAM_ADDRESS_BITS    12
`define TRIGGER_ADDR        1280    // first word of slot 2

// --------------------
// capture windows
// --------------------
`define P_H_START           44      // progressive
`define P_H_END             684
`define P_V_END             480
`define D_H_START           1       // line doubler
`define D_H_END             641
`define D_V_END             504
`define D_GAP_START         240     // blank band between the two fields
`define D_GAP_END           263

`endif

// ==== files.f ====
+incdir+common
common/capturePkg.sv
logic/videoTimingCounter.sv
capture/frameCapture.sv
logic/lineBufferRam.sv
output/bufferReader.sv
logic/videoCaptureTop.sv
verif/videoCapture_chk.sv
verif/videoCaptureTb.sv

// ==== logic/lineBufferRam.sv ====
`default_nettype none

`include "capture_config.svh"

module lineBufferRam import capturePkg::*; (
    input  logic                         clock,
    input  capturePkg::ramWrite          ramWrite,
    input  logic [`RAM_ADDRESS_BITS-1:0] readAddr,
    output pixel                         readData
);

    localparam int DEPTH = `BUFFER_LINE_LENGTH * `BUFFER_SIZE;

    pixel mem [0:DEPTH-1];

    // write port
    always_ff @(posedge clock) begin
        if (ramWrite.en) begin
            mem[ramWrite.addr] <= ramWrite.data;
        end
    end

    // registered read, old data on a same-address collision
    always_ff @(posedge clock) begin
        readData <= mem[readAddr];
    end

endmodule

`default_nettype wire

// ==== logic/videoCaptureTop.sv ====
`default_nettype none

`include "capture_config.svh"

module videoCaptureTop import capturePkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     hsync,
    input  logic     vsync,
    input  logic     lineDoubler,
    input  pixel     inPixel,
    output pixel     outPixel,
    output rasterPos outPos,
    output logic     outValid,
    output logic     startTrigger
);

    rasterPos                     srcPos;
    pixel                         srcPixel;
    capturePkg::ramWrite          writePort;
    logic [`RAM_ADDRESS_BITS-1:0] readAddr;
    pixel                         readData;

    // --------------------
    // source side
    // --------------------
    videoTimingCounter u_videoTimingCounter (
        .clock    (clock),
        .reset    (reset),
        .hsync    (hsync),
        .vsync    (vsync),
        .inPixel  (inPixel),
        .pos      (srcPos),
        .pixelOut (srcPixel)
    );

    frameCapture u_frameCapture (
        .clock        (clock),
        .reset        (reset),
        .lineDoubler  (lineDoubler),
        .pos          (srcPos),
        .pixelIn      (srcPixel),
        .ramWrite     (writePort),
        .startTrigger (startTrigger)
    );

    lineBufferRam u_lineBufferRam (
        .clock    (clock),
        .ramWrite (writePort),
        .readAddr (readAddr),
        .readData (readData)
    );

    // --------------------
    // output side
    // --------------------
    bufferReader u_bufferReader (
        .clock        (clock),
        .reset        (reset),
        .lineDoubler  (lineDoubler),
        .startTrigger (startTrigger),
        .readAddr     (readAddr),
        .readData     (readData),
        .outPixel     (outPixel),
        .outPos       (outPos),
        .outValid     (outValid)
    );

endmodule

`default_nettype wire

// ==== logic/videoTimingCounter.sv ====
`default_nettype none

module videoTimingCounter import capturePkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     hsync,
    input  logic     vsync,
    input  pixel     inPixel,
    output rasterPos pos,
    output pixel     pixelOut
);

    localparam logic [11:0] COUNT_MAX = 12'hFFF;

    // --------------------
    // column and line counters
    // --------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            pos.x <= '0;
            pos.y <= '0;
        end else begin
            if (hsync) begin
                pos.x <= '0;                        // first pixel of the line
                if (vsync) begin
                    pos.y <= '0;
                end else if (pos.y != COUNT_MAX) begin
                    pos.y <= pos.y + 12'd1;
                end
            end else if (pos.x != COUNT_MAX) begin
                pos.x <= pos.x + 12'd1;             // holds if hsync goes missing
            end
        end
    end

    // pixel follows its position by the same one cycle
    always_ff @(posedge clock) begin
        pixelOut <= inPixel;
    end

endmodule

`default_nettype wire

// ==== output/bufferReader.sv ====
`default_nettype none

`include "capture_config.svh"

module bufferReader import capturePkg::*; (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         lineDoubler,
    input  logic                         startTrigger,
    output logic [`RAM_ADDRESS_BITS-1:0] readAddr,
    input  pixel                         readData,
    output pixel                         outPixel,
    output rasterPos                     outPos,
    output logic                         outValid
);

    logic        running;
    logic [11:0] rasterX;
    logic [11:0] rasterY;

    logic [11:0] hStart;
    logic [11:0] hEnd;
    logic [11:0] vEnd;
    logic        inGap;
    logic        inWindow;

    logic [`RAM_ADDRESS_BITS-1:0] slotBase;
    logic [`RAM_ADDRESS_BITS-1:0] column;

    rasterPos addrPos;
    logic     addrValid;

    // --------------------
    // output raster counter
    // --------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            running <= 1'b0;
            rasterX <= '0;
            rasterY <= '0;
        end else if (startTrigger) begin
            running <= 1'b1;
            rasterX <= '0;
            rasterY <= 12'd2;                       // line marked by the trigger
        end else if (running) begin
            if (rasterX == 12'(`H_TOTAL - 1)) begin
                rasterX <= '0;
                rasterY <= (rasterY == 12'(`V_TOTAL - 1)) ? '0 : rasterY + 12'd1;
            end else begin
                rasterX <= rasterX + 12'd1;
            end
        end
    end

    // --------------------
    // window rules
    // --------------------
    always_comb begin
        if (lineDoubler) begin
            hStart = 12'(`D_H_START);
            hEnd   = 12'(`D_H_END);
            vEnd   = 12'(`D_V_END);
        end else begin
            hStart = 12'(`P_H_START);
            hEnd   = 12'(`P_H_END);
            vEnd   = 12'(`P_V_END);
        end
    end

    assign inGap = lineDoubler
                && rasterY >= 12'(`D_GAP_START)
                && rasterY <  12'(`D_GAP_END);

    assign inWindow = running
                   && rasterX >= hStart
                   && rasterX <  hEnd
                   && rasterY <  vEnd
                   && !inGap;

    // same ring address as the writer
    assign slotBase = `RAM_ADDRESS_BITS'(`BUFFER_LINE_LENGTH * (rasterY % `BUFFER_SIZE));
    assign column   = `RAM_ADDRESS_BITS'(rasterX - hStart);

    // --------------------
    // address stage
    // --------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            addrValid <= 1'b0;
        end else begin
            addrValid <= inWindow;
        end
    end

    always_ff @(posedge clock) begin
        readAddr  <= slotBase + column;
        addrPos.x <= rasterX - hStart;              // re-based to column 0
        addrPos.y <= rasterY;
    end

    // --------------------
    // RAM read stage
    // --------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= addrValid;
        end
    end

    always_ff @(posedge clock) begin
        outPos <= addrPos;
    end

    assign outPixel = readData;                     // already one cycle behind readAddr

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing --timescale 1ns/100ps \
    --top-module videoCaptureTb -f files.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -qx "all tests passed" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== verif/videoCaptureTb.sv ====
`default_nettype none

`include "capture_config.svh"

module videoCaptureTb import capturePkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAMES_TO_RUN   = 6;
    localparam int DOUBLER_FROM    = 3;                     // first line-doubler frame
    localparam int FRAME_CYCLES    = `H_TOTAL * `V_TOTAL;
    localparam int TRIGGER_TIMEOUT = 4 * `H_TOTAL;

    logic     clock       = 1'b0;
    logic     reset       = 1'b1;
    logic     hsync       = 1'b0;
    logic     vsync       = 1'b0;
    logic     lineDoubler = 1'b0;
    pixel     inPixel     = '0;
    pixel     outPixel;
    rasterPos outPos;
    logic     outValid;
    logic     startTrigger;

    // source raster
    int          srcX          = 0;
    int          srcY          = 0;
    int          drivenLine    = 0;
    int          framesStarted = 0;
    logic [31:0] rngState      = 32'd73866;
    logic [31:0] frameSeed     = 32'd73866;
    logic [31:0] prevSeed      = 32'd73866;

    // output side
    rasterPos expectPos     = '{x: 12'd0, y: 12'd2};       // reader starts on line 2
    logic     frameMode     = 1'b0;
    int       framesSeen    = 0;
    int       framesChecked = 0;
    int       validCount    = 0;
    int       triggerCount  = 0;

    // --------------------
    // reference model
    // --------------------
    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int hStartOf(input logic mode);
        return mode ? `D_H_START : `P_H_START;
    endfunction

    function automatic int widthOf(input logic mode);
        return mode ? `D_H_END - `D_H_START : `P_H_END - `P_H_START;
    endfunction

    function automatic int linesOf(input logic mode);
        return mode ? `D_GAP_START + `D_V_END - `D_GAP_END : `P_V_END;
    endfunction

    // next captured line skipping the blank band and wrapping at the window end
    function automatic int nextLine(input int y, input logic mode);
        if (mode && y == `D_GAP_START - 1) begin
            return `D_GAP_END;
        end
        if (y == (mode ? `D_V_END : `P_V_END) - 1) begin
            return 0;
        end
        return y + 1;
    endfunction

    function automatic pixel sourcePixel(input int x, input int y, input logic [31:0] seed);
        logic [31:0] h;
        h = seed ^ (32'(x) * 32'h9E3779B1) ^ (32'(y) * 32'h85EBCA6B);
        h = h ^ (h >> 13);
        h = h * 32'hC2B2AE35;
        h = h ^ (h >> 16);
        return pixel'(h[23:0]);
    endfunction

    function automatic pixel expectedPixel(input int x, input int y,
                                           input logic [31:0] seed, input logic mode);
        return sourcePixel(x + hStartOf(mode), y, seed);
    endfunction

    // --------------------
    // checks
    // --------------------
    task automatic failTest(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic checkPixel(input string name, input pixel expected, input pixel actual);
        if (actual !== expected) begin
            failTest($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkPos(input string name, input rasterPos expected, input rasterPos actual);
        if (actual !== expected) begin
            failTest($sformatf("mismatch %s expected (%0d,%0d) actual (%0d,%0d)", name,
                               expected.x, expected.y, actual.x, actual.y));
        end
    endtask

    task automatic checkCount(input string name, input int expected, input int actual);
        if (actual != expected) begin
            failTest($sformatf("mismatch %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic closeFrame();
        if (framesStarted >= 2) begin
            checkCount($sformatf("start triggers in frame %0d", framesStarted - 2),
                       1, triggerCount);
            framesChecked++;
        end
        if (framesStarted >= 3) begin                       // the reader joins frame 0 at line 2
            checkCount($sformatf("valid pixels in frame %0d", framesStarted - 2),
                       widthOf(frameMode) * linesOf(frameMode), validCount);
        end
        triggerCount = 0;
        validCount   = 0;
        frameMode    = lineDoubler;
        framesSeen   = framesStarted;
    endtask

    task automatic checkOutput();
        logic [31:0] seed;
        pixel        expected;
        if (lineDoubler && outPos.y >= `D_GAP_START && outPos.y < `D_GAP_END) begin
            failTest($sformatf("valid output on line %0d inside the blank band", outPos.y));
        end
        checkPos("output position", expectPos, outPos);
        // a line ahead of the source belongs to the previous frame
        seed     = (int'(outPos.y) <= drivenLine) ? frameSeed : prevSeed;
        expected = expectedPixel(int'(outPos.x), int'(outPos.y), seed, lineDoubler);
        checkPixel($sformatf("pixel at (%0d,%0d)", outPos.x, outPos.y), expected, outPixel);
        validCount++;
        if (int'(expectPos.x) == widthOf(lineDoubler) - 1) begin
            expectPos.x = '0;
            expectPos.y = 12'(nextLine(int'(expectPos.y), lineDoubler));
        end else begin
            expectPos.x = expectPos.x + 12'd1;
        end
    endtask

    // --------------------
    // DUT
    // --------------------
    videoCaptureTop u_videoCaptureTop (
        .clock        (clock),
        .reset        (reset),
        .hsync        (hsync),
        .vsync        (vsync),
        .lineDoubler  (lineDoubler),
        .inPixel      (inPixel),
        .outPixel     (outPixel),
        .outPos       (outPos),
        .outValid     (outValid),
        .startTrigger (startTrigger)
    );

    bind videoCaptureTop videoCapture_chk u_videoCapture_chk (
        .clock        (clock),
        .reset        (reset),
        .startTrigger (startTrigger),
        .outValid     (outValid),
        .writePort    (writePort)
    );

    initial begin
        forever begin
            #5 clock = ~clock;
        end
    end

    // source raster with one pixel per cycle
    always @(posedge clock) begin
        if (!reset) begin
            if (srcX == 0 && srcY == 0) begin
                prevSeed    = frameSeed;
                rngState    = lcgNext(rngState);
                frameSeed   = rngState;
                lineDoubler <= (framesStarted >= DOUBLER_FROM);
                framesStarted++;
            end
            hsync      <= (srcX == 0);
            vsync      <= (srcX == 0 && srcY == 0);
            inPixel    <= sourcePixel(srcX, srcY, frameSeed);
            drivenLine = srcY;
            if (srcX == `H_TOTAL - 1) begin
                srcX = 0;
                srcY = (srcY == `V_TOTAL - 1) ? 0 : srcY + 1;
            end else begin
                srcX = srcX + 1;
            end
        end
    end

    // compare process on the falling edge
    always @(negedge clock) begin
        if (!reset) begin
            if (framesStarted != framesSeen) begin
                closeFrame();
            end
            if (startTrigger) begin
                triggerCount++;
            end
            if (outValid) begin
                checkOutput();
            end
        end
    end

    initial begin
        int waitCycles;
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        waitCycles = 0;
        while (startTrigger !== 1'b1) begin
            @(negedge clock);
            if (outValid !== 1'b0) begin
                failTest("outValid went high before the first start trigger");
            end
            waitCycles++;
            if (waitCycles > TRIGGER_TIMEOUT) begin
                failTest("timed out waiting for the first start trigger");
            end
        end

        waitCycles = 0;
        while (framesChecked < FRAMES_TO_RUN) begin
            @(negedge clock);
            waitCycles++;
            if (waitCycles > (FRAMES_TO_RUN + 2) * FRAME_CYCLES) begin
                failTest("timed out waiting for the frames to complete");
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/videoCapture_chk.sv ====
`default_nettype none

`include "capture_config.svh"

module videoCapture_chk import capturePkg::*; (
    input logic    clock,
    input logic    reset,
    input logic    startTrigger,
    input logic    outValid,
    input ramWrite writePort
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RAM_DEPTH = `BUFFER_LINE_LENGTH * `BUFFER_SIZE;

    // --------------------
    // capture side
    // --------------------
    triggerOneCycle: assert property (
        @(posedge clock) disable iff (reset)
        startTrigger |=> !startTrigger
    ) else $error("start trigger lasted more than one cycle");

    writeInRange: assert property (
        @(posedge clock) disable iff (reset)
        writePort.en |-> int'(writePort.addr) < RAM_DEPTH
    ) else $error("line buffer write address beyond the ring");

    // --------------------
    // reader side
    // --------------------
    // outValid is a register, low from the first reset edge on
    validLowInReset: assert property (
        @(posedge clock)
        reset |=> !outValid
    ) else $error("outValid high during reset");

endmodule

`default_nettype wire
